// File: files.f
rtl/sa_pkg.sv
rtl/sa_row_buffer.sv
rtl/sa_pe.sv
rtl/sa_mmu.sv
rtl/sa_accumulator.sv
rtl/sa_control.sv
rtl/sa_top.sv
verif/sa_assertions.sv
verif/sa_tb.sv

// File: rtl/sa_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module sa_accumulator import sa_pkg::*; (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic              wr_add,
    input  logic [RES_W-1:0]  wr_row,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [RES_W-1:0]  rd_row
);

    logic [RES_W-1:0] mem [BUF_DEPTH];
    logic [RES_W-1:0] new_row;

    // Per-element add wraps at 2^ACC_W
    always_comb begin
        for (int j = 0; j < ARRAY_N; j++) begin
            if (wr_add) begin
                new_row[j*ACC_W +: ACC_W] = mem[wr_addr][j*ACC_W +: ACC_W]
                                          + wr_row[j*ACC_W +: ACC_W];
            end else begin
                new_row[j*ACC_W +: ACC_W] = wr_row[j*ACC_W +: ACC_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= new_row;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_row <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/sa_control.sv
`timescale 1ns/1ps
`default_nettype none

module sa_control import sa_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  instr_t            instr,
    input  logic              instr_valid,
    output logic              instr_ready,
    output logic              ub_we,
    output logic              wb_we,
    output logic [ADDR_W-1:0] buf_waddr,
    output logic [ROW_W-1:0]  buf_wdata,
    output logic              ub_re,
    output logic [ADDR_W-1:0] ub_raddr,
    output logic              wb_re,
    output logic [ADDR_W-1:0] wb_raddr,
    output logic              weight_shift,
    output logic              act_valid,
    output logic [TAG_W-1:0]  act_tag,
    input  logic              mmu_out_valid,
    output logic              acc_rd_en,
    output logic [ADDR_W-1:0] acc_rd_addr,
    input  logic [RES_W-1:0]  acc_rd_row,
    output logic [RES_W-1:0]  result_data,
    output logic              result_valid,
    input  logic              result_ready
);

    logic [STATE_W-1:0] state;
    instr_t             instr_q;
    logic [ADDR_W:0]    row_cnt;
    logic [ADDR_W:0]    pending;
    logic               wb_rd_q;
    logic               ub_rd_q;
    logic [TAG_W-1:0]   tag_q;
    logic [RES_W-1:0]   result_q;
    logic               accept;
    logic               reads_done;

    assign instr_ready = (state == ST_IDLE);
    assign accept      = instr_valid && instr_ready;
    assign reads_done  = (row_cnt > {1'b0, instr_q.exec.count});

    //////////////////////////////////////////////////
    // Datapath controls
    //////////////////////////////////////////////////

    // Buffer writes through the mem view
    assign ub_we     = (state == ST_STEP) && (instr_q.mem.opcode == OP_WRITE_UB);
    assign wb_we     = (state == ST_STEP) && (instr_q.mem.opcode == OP_WRITE_WB);
    assign buf_waddr = instr_q.mem.addr;
    assign buf_wdata = instr_q.mem.data;

    // Weight rows go out last-first so src_addr lands in PE row 0
    assign wb_re    = (state == ST_LOAD) && (row_cnt < ARRAY_N);
    assign wb_raddr = instr_q.exec.src_addr + ADDR_W'(ARRAY_N - 1) - row_cnt[ADDR_W-1:0];

    assign ub_re    = (state == ST_MATMUL) && !reads_done;
    assign ub_raddr = instr_q.exec.src_addr + row_cnt[ADDR_W-1:0];

    // Buffer data shows up one cycle after the read
    assign weight_shift = wb_rd_q;
    assign act_valid    = ub_rd_q;
    assign act_tag      = tag_q;

    assign acc_rd_en    = (state == ST_READ);
    assign acc_rd_addr  = instr_q.exec.dst_addr;
    assign result_valid = (state == ST_RESULT);
    assign result_data  = result_q;

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            row_cnt <= '0;
            pending <= '0;
            wb_rd_q <= 1'b0;
            ub_rd_q <= 1'b0;
        end else begin
            wb_rd_q <= wb_re;
            ub_rd_q <= ub_re;
            // Rows issued to the MMU but not yet written back
            pending <= pending + {{ADDR_W{1'b0}}, ub_re} - {{ADDR_W{1'b0}}, mmu_out_valid};
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        row_cnt <= '0;
                        case (instr.mem.opcode)
                            OP_LOAD_W:   state <= ST_LOAD;
                            OP_MATMUL:   state <= ST_MATMUL;
                            OP_READ_ACC: state <= ST_READ;
                            default:     state <= ST_STEP;
                        endcase
                    end
                end
                ST_STEP: state <= ST_IDLE;
                ST_LOAD: begin
                    row_cnt <= row_cnt + 1'b1;
                    if (row_cnt == ARRAY_N) begin
                        state <= ST_IDLE;
                    end
                end
                ST_MATMUL: begin
                    if (!reads_done) begin
                        row_cnt <= row_cnt + 1'b1;
                    end else if (pending == '0) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ:    state <= ST_CAPTURE;
                ST_CAPTURE: state <= ST_RESULT;
                ST_RESULT: begin
                    if (result_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
        tag_q <= {instr_q.exec.accumulate, instr_q.exec.dst_addr + row_cnt[ADDR_W-1:0]};
        if (state == ST_CAPTURE) begin
            result_q <= acc_rd_row;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sa_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module sa_mmu import sa_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              weight_shift,
    input  logic [ROW_W-1:0]  weight_row,
    input  logic              act_valid,
    input  logic [ROW_W-1:0]  act_row,
    input  logic [TAG_W-1:0]  act_tag,
    output logic              out_valid,
    output logic [RES_W-1:0]  out_row,
    output logic [TAG_W-1:0]  out_tag
);

    // a moves right, weights and partial sums move down
    logic [ELEM_W-1:0] a_h [ARRAY_N][ARRAY_N+1];
    logic [ELEM_W-1:0] w_v [ARRAY_N+1][ARRAY_N];
    logic [ACC_W-1:0]  p_v [ARRAY_N+1][ARRAY_N];
    logic [ACC_W-1:0]  col_out [ARRAY_N];

    logic [MMU_LATENCY-1:0] vld_q;
    logic [TAG_W-1:0]       tag_q [MMU_LATENCY];

    //////////////////////////////////////////////////
    // Input skew
    //////////////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_N; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_h[i][0] = act_row[ELEM_W-1:0];
        end else begin : g_delay
            logic [ELEM_W-1:0] stage [i];
            always_ff @(posedge clk) begin
                stage[0] <= act_row[i*ELEM_W +: ELEM_W];
                for (int k = 1; k < i; k++) begin
                    stage[k] <= stage[k-1];
                end
            end
            assign a_h[i][0] = stage[i-1];
        end
    end

    //////////////////////////////////////////////////
    // PE grid
    //////////////////////////////////////////////////

    for (genvar j = 0; j < ARRAY_N; j++) begin : g_top_edge
        assign w_v[0][j] = weight_row[j*ELEM_W +: ELEM_W];
        assign p_v[0][j] = '0;
    end

    for (genvar i = 0; i < ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_N; j++) begin : g_col
            sa_pe i_pe (
                .clk      (clk),
                .rst      (rst),
                .w_shift  (weight_shift),
                .w_in     (w_v[i][j]),
                .w_out    (w_v[i+1][j]),
                .a_in     (a_h[i][j]),
                .a_out    (a_h[i][j+1]),
                .psum_in  (p_v[i][j]),
                .psum_out (p_v[i+1][j])
            );
        end
    end

    //////////////////////////////////////////////////
    // Output deskew
    //////////////////////////////////////////////////

    // Column j leaves the grid j cycles after column 0
    for (genvar j = 0; j < ARRAY_N; j++) begin : g_deskew
        if (j == ARRAY_N - 1) begin : g_direct
            assign col_out[j] = p_v[ARRAY_N][j];
        end else begin : g_delay
            logic [ACC_W-1:0] stage [ARRAY_N-1-j];
            always_ff @(posedge clk) begin
                stage[0] <= p_v[ARRAY_N][j];
                for (int k = 1; k < ARRAY_N - 1 - j; k++) begin
                    stage[k] <= stage[k-1];
                end
            end
            assign col_out[j] = stage[ARRAY_N-2-j];
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < ARRAY_N; j++) begin
            out_row[j*ACC_W +: ACC_W] <= col_out[j];
        end
    end

    // Valid and tag follow the row through the array
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MMU_LATENCY-2:0], act_valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= act_tag;
        for (int k = 1; k < MMU_LATENCY; k++) begin
            tag_q[k] <= tag_q[k-1];
        end
    end

    assign out_valid = vld_q[MMU_LATENCY-1];
    assign out_tag   = tag_q[MMU_LATENCY-1];

endmodule

`default_nettype wire

// File: rtl/sa_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sa_pe import sa_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              w_shift,
    input  logic [ELEM_W-1:0] w_in,
    output logic [ELEM_W-1:0] w_out,
    input  logic [ELEM_W-1:0] a_in,
    output logic [ELEM_W-1:0] a_out,
    input  logic [ACC_W-1:0]  psum_in,
    output logic [ACC_W-1:0]  psum_out
);

    logic signed [PROD_W-1:0] prod;

    // Stationary weight, moves one row down per shift
    always_ff @(posedge clk) begin
        if (w_shift) begin
            w_out <= w_in;
        end
    end

    assign prod = $signed(a_in) * $signed(w_out);

    always_ff @(posedge clk) begin
        if (rst) begin
            a_out    <= '0;
            psum_out <= '0;
        end else begin
            a_out    <= a_in;
            psum_out <= psum_in + {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
        end
    end

endmodule

`default_nettype wire

// File: rtl/sa_pkg.sv
`default_nettype none

package sa_pkg;

    //////////////////////////////////////////////////
    // Array and buffer sizes
    //////////////////////////////////////////////////

    localparam int ARRAY_N     = 4;
    localparam int ELEM_W      = 8;
    localparam int ROW_W       = ARRAY_N * ELEM_W;
    localparam int PROD_W      = 2 * ELEM_W;
    localparam int ACC_W       = 20;
    localparam int RES_W       = ARRAY_N * ACC_W;
    localparam int BUF_DEPTH   = 16;
    localparam int ADDR_W      = 4;
    localparam int MMU_LATENCY = 2 * ARRAY_N;

    // Tag carried with each activation row: {accumulate, dst address}
    localparam int TAG_W = ADDR_W + 1;

    //////////////////////////////////////////////////
    // Instruction format
    //////////////////////////////////////////////////

    localparam int OPC_W   = 4;
    localparam int CNT_W   = 4;
    localparam int INSTR_W = OPC_W + ADDR_W + ROW_W;
    localparam int PAD_W   = INSTR_W - OPC_W - 2 * ADDR_W - CNT_W - 1;

    localparam logic [OPC_W-1:0] OP_NOP      = 4'h0;
    localparam logic [OPC_W-1:0] OP_WRITE_UB = 4'h1;
    localparam logic [OPC_W-1:0] OP_WRITE_WB = 4'h2;
    localparam logic [OPC_W-1:0] OP_LOAD_W   = 4'h3;
    localparam logic [OPC_W-1:0] OP_MATMUL   = 4'h4;
    localparam logic [OPC_W-1:0] OP_READ_ACC = 4'h5;

    // Opcode sits in the same bits in both views
    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]  opcode;
            logic [ADDR_W-1:0] addr;
            logic [ROW_W-1:0]  data;
        } mem;
        struct packed {
            logic [OPC_W-1:0]  opcode;
            logic [ADDR_W-1:0] src_addr;
            logic [ADDR_W-1:0] dst_addr;
            logic [CNT_W-1:0]  count;
            logic              accumulate;
            logic [PAD_W-1:0]  pad;
        } exec;
    } instr_t;

    //////////////////////////////////////////////////
    // Control FSM state codes
    //////////////////////////////////////////////////

    localparam int STATE_W = 3;

    localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] ST_STEP    = 3'd1;
    localparam logic [STATE_W-1:0] ST_LOAD    = 3'd2;
    localparam logic [STATE_W-1:0] ST_MATMUL  = 3'd3;
    localparam logic [STATE_W-1:0] ST_READ    = 3'd4;
    localparam logic [STATE_W-1:0] ST_CAPTURE = 3'd5;
    localparam logic [STATE_W-1:0] ST_RESULT  = 3'd6;

endpackage

`default_nettype wire

// File: rtl/sa_row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sa_row_buffer import sa_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [ROW_W-1:0]  wdata,
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [ROW_W-1:0]  rdata
);

    logic [ROW_W-1:0] mem [BUF_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, holds last value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/sa_top.sv
`timescale 1ns/1ps
`default_nettype none

module sa_top import sa_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  instr_t           instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    output logic [RES_W-1:0] result_data,
    output logic             result_valid,
    input  logic             result_ready
);

    // Buffer controls
    logic              ub_we;
    logic              wb_we;
    logic [ADDR_W-1:0] buf_waddr;
    logic [ROW_W-1:0]  buf_wdata;
    logic              ub_re;
    logic [ADDR_W-1:0] ub_raddr;
    logic [ROW_W-1:0]  ub_rdata;
    logic              wb_re;
    logic [ADDR_W-1:0] wb_raddr;
    logic [ROW_W-1:0]  wb_rdata;

    // MMU and accumulator paths
    logic              weight_shift;
    logic              act_valid;
    logic [TAG_W-1:0]  act_tag;
    logic              mmu_out_valid;
    logic [RES_W-1:0]  mmu_out_row;
    logic [TAG_W-1:0]  mmu_out_tag;
    logic              acc_rd_en;
    logic [ADDR_W-1:0] acc_rd_addr;
    logic [RES_W-1:0]  acc_rd_row;

    sa_control i_control (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .instr_ready   (instr_ready),
        .ub_we         (ub_we),
        .wb_we         (wb_we),
        .buf_waddr     (buf_waddr),
        .buf_wdata     (buf_wdata),
        .ub_re         (ub_re),
        .ub_raddr      (ub_raddr),
        .wb_re         (wb_re),
        .wb_raddr      (wb_raddr),
        .weight_shift  (weight_shift),
        .act_valid     (act_valid),
        .act_tag       (act_tag),
        .mmu_out_valid (mmu_out_valid),
        .acc_rd_en     (acc_rd_en),
        .acc_rd_addr   (acc_rd_addr),
        .acc_rd_row    (acc_rd_row),
        .result_data   (result_data),
        .result_valid  (result_valid),
        .result_ready  (result_ready)
    );

    // Unified buffer
    sa_row_buffer i_ub (
        .clk   (clk),
        .we    (ub_we),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .re    (ub_re),
        .raddr (ub_raddr),
        .rdata (ub_rdata)
    );

    // Weight buffer
    sa_row_buffer i_wb (
        .clk   (clk),
        .we    (wb_we),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .re    (wb_re),
        .raddr (wb_raddr),
        .rdata (wb_rdata)
    );

    sa_mmu i_mmu (
        .clk          (clk),
        .rst          (rst),
        .weight_shift (weight_shift),
        .weight_row   (wb_rdata),
        .act_valid    (act_valid),
        .act_row      (ub_rdata),
        .act_tag      (act_tag),
        .out_valid    (mmu_out_valid),
        .out_row      (mmu_out_row),
        .out_tag      (mmu_out_tag)
    );

    // Tag splits into destination row and accumulate flag
    sa_accumulator i_acc (
        .clk     (clk),
        .wr_en   (mmu_out_valid),
        .wr_addr (mmu_out_tag[ADDR_W-1:0]),
        .wr_add  (mmu_out_tag[ADDR_W]),
        .wr_row  (mmu_out_row),
        .rd_en   (acc_rd_en),
        .rd_addr (acc_rd_addr),
        .rd_row  (acc_rd_row)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the systolic array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module sa_tb \
    --Mdir obj_dir \
    -f files.f

# Run and keep a log
./obj_dir/Vsa_tb 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "Run passed"
    exit 0
else
    echo "Run failed"
    exit 1
fi

// File: verif/sa_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sa_assertions import sa_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             instr_ready,
    input logic [RES_W-1:0] result_data,
    input logic             result_valid,
    input logic             result_ready
);

    // Result is held until taken
    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result_data))
        else $error("result_valid or result_data changed before the handshake");

    // Control is busy while a result waits
    a_ready_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(instr_ready && result_valid))
        else $error("instr_ready and result_valid were high together");

    a_reset_state: assert property (@(posedge clk)
        rst |=> instr_ready && !result_valid)
        else $error("instr_ready low or result_valid high after reset");

endmodule

bind sa_top sa_assertions i_sa_assertions (
    .clk          (clk),
    .rst          (rst),
    .instr_ready  (instr_ready),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready)
);

`default_nettype wire

// File: verif/sa_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sa_tb
    import sa_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int SEED       = 80370;

    logic               clk;
    logic               rst;
    logic [INSTR_W-1:0] instr;
    logic               instr_valid;
    logic               instr_ready;
    logic [RES_W-1:0]   result_data;
    logic               result_valid;
    logic               result_ready;

    // Testbench copies of buffer, tile and accumulator contents
    logic [ROW_W-1:0] ub_model [BUF_DEPTH];
    logic [ROW_W-1:0] wb_model [BUF_DEPTH];
    logic [RES_W-1:0] acc_model [BUF_DEPTH];
    logic [ROW_W-1:0] w_tile [ARRAY_N];

    // Expected rows in read order
    logic [RES_W-1:0] exp_q [$];

    string test_name;
    int    checks;
    int    errors;
    int    test_errors_start;
    int    tests_run;
    int    tests_failed;

    sa_top i_sa_top (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result_data  (result_data),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Element j = sum over i of a[i] * W[i][j], wrapped to ACC_W bits
    function automatic logic [RES_W-1:0] ref_row(input logic [ROW_W-1:0] a_row,
                                                 input logic [RES_W-1:0] old_row,
                                                 input bit accumulate);
        logic [RES_W-1:0] res;
        logic [ACC_W-1:0] elem;
        int               sum;
        for (int j = 0; j < ARRAY_N; j++) begin
            sum = 0;
            for (int i = 0; i < ARRAY_N; i++) begin
                sum += int'($signed(a_row[i*ELEM_W +: ELEM_W]))
                     * int'($signed(w_tile[i][j*ELEM_W +: ELEM_W]));
            end
            elem = sum[ACC_W-1:0];
            if (accumulate) begin
                elem = elem + old_row[j*ACC_W +: ACC_W];
            end
            res[j*ACC_W +: ACC_W] = elem;
        end
        return res;
    endfunction

    function automatic logic [INSTR_W-1:0] mem_word(input logic [OPC_W-1:0] op,
                                                    input logic [ADDR_W-1:0] addr,
                                                    input logic [ROW_W-1:0] data);
        return {op, addr, data};
    endfunction

    function automatic logic [INSTR_W-1:0] exec_word(input logic [OPC_W-1:0] op,
                                                     input logic [ADDR_W-1:0] src,
                                                     input logic [ADDR_W-1:0] dst,
                                                     input logic [CNT_W-1:0] count,
                                                     input bit accumulate);
        return {op, src, dst, count, accumulate, {PAD_W{1'b0}}};
    endfunction

    // Extremes show up often
    function automatic logic [ELEM_W-1:0] rand_elem();
        case ($urandom % 6)
            0: return 8'h80;
            1: return 8'h7f;
            default: return ELEM_W'($urandom);
        endcase
    endfunction

    function automatic logic [ROW_W-1:0] rand_row();
        logic [ROW_W-1:0] row;
        for (int i = 0; i < ARRAY_N; i++) begin
            row[i*ELEM_W +: ELEM_W] = rand_elem();
        end
        return row;
    endfunction

    //////////////////////////////////////////////////
    // Result checker
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [RES_W-1:0] expected;
        if (!rst && result_valid && result_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A result row arrived that nobody asked for in test %s", test_name);
            end else begin
                expected = exp_q.pop_front();
                if (result_data !== expected) begin
                    errors++;
                    $display("** Error [%s]: expected %h, actual %h",
                             test_name, expected, result_data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s in test %s", what, test_name);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("** Error [%s %s]: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // Called at 2 ns after an edge
    task automatic wait_ready(output int cycles);
        cycles = 0;
        while (!instr_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!instr_ready) begin
            abort_run("Timeout while waiting for instr_ready");
        end
    endtask

    task automatic send_instr(input logic [INSTR_W-1:0] word);
        int cycles;
        instr       = word;
        instr_valid = 1'b1;
        wait_ready(cycles);
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
    endtask

    task automatic write_row(input bit to_wb, input logic [ADDR_W-1:0] addr,
                             input logic [ROW_W-1:0] data);
        int cycles;
        send_instr(mem_word(to_wb ? OP_WRITE_WB : OP_WRITE_UB, addr, data));
        wait_ready(cycles);
        if (to_wb) begin
            wb_model[addr] = data;
        end else begin
            ub_model[addr] = data;
        end
    endtask

    task automatic load_weights(input logic [ADDR_W-1:0] src);
        int cycles;
        send_instr(exec_word(OP_LOAD_W, src, 4'h0, 4'h0, 1'b0));
        wait_ready(cycles);
        for (int i = 0; i < ARRAY_N; i++) begin
            w_tile[i] = wb_model[src + ADDR_W'(i)];
        end
    endtask

    task automatic matmul(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                          input logic [CNT_W-1:0] count, input bit accumulate);
        int                cycles;
        logic [ADDR_W-1:0] a_addr;
        logic [ADDR_W-1:0] d_addr;
        send_instr(exec_word(OP_MATMUL, src, dst, count, accumulate));
        wait_ready(cycles);
        for (int k = 0; k <= int'(count); k++) begin
            a_addr            = src + ADDR_W'(k);
            d_addr            = dst + ADDR_W'(k);
            acc_model[d_addr] = ref_row(ub_model[a_addr], acc_model[d_addr], accumulate);
        end
    endtask

    // Stall cycles hold result_ready low while a NOP is offered
    task automatic read_check(input logic [ADDR_W-1:0] addr, input int stall);
        int cycles;
        exp_q.push_back(acc_model[addr]);
        send_instr(exec_word(OP_READ_ACC, 4'h0, addr, 4'h0, 1'b0));
        cycles = 0;
        while (!result_valid && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!result_valid) begin
            abort_run("Timeout while waiting for result_valid");
        end
        instr       = exec_word(OP_NOP, 4'h0, 4'h0, 4'h0, 1'b0);
        instr_valid = (stall > 0);
        for (int s = 0; s < stall; s++) begin
            checks++;
            if (instr_ready) begin
                errors++;
                $display("An instruction could be accepted while a result was pending in test %s",
                         test_name);
            end
            @(posedge clk);
            #2;
        end
        instr_valid  = 1'b0;
        result_ready = 1'b1;
        @(posedge clk);
        #2;
        result_ready = 1'b0;
        wait_ready(cycles);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        if (exp_q.size() != 0) begin
            errors++;
            $display("Expected result rows never came back in test %s", test_name);
            exp_q.delete();
        end
        tests_run++;
        if (errors == test_errors_start) begin
            $display("Test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, test_name,
                     errors - test_errors_start);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        int cycles;
        start_test("reset_state");
        check_value("instr_ready", 1, int'(instr_ready));
        check_value("result_valid", 0, int'(result_valid));
        send_instr(exec_word(OP_NOP, 4'h0, 4'h0, 4'h0, 1'b0));
        wait_ready(cycles);
        check_value("nop busy cycles", 1, cycles);
        // Undefined opcode
        send_instr(exec_word(4'hf, 4'h3, 4'h7, 4'h2, 1'b1));
        wait_ready(cycles);
        check_value("undefined busy cycles", 1, cycles);
        check_value("result_valid", 0, int'(result_valid));
        end_test();
    endtask

    task automatic test_identity();
        start_test("identity");
        for (int i = 0; i < ARRAY_N; i++) begin
            write_row(1'b1, ADDR_W'(4 + i), ROW_W'(1) << (i * ELEM_W));
            write_row(1'b0, ADDR_W'(i), rand_row());
        end
        load_weights(4'd4);
        matmul(4'd0, 4'd0, 4'd3, 1'b0);
        for (int i = 0; i < ARRAY_N; i++) begin
            read_check(ADDR_W'(i), 0);
        end
        end_test();
    endtask

    task automatic test_random_tiles();
        int wbase_list [4] = '{0, 14, 7, 9};
        int src_list [4]   = '{0, 3, 14, 5};
        int dst_list [4]   = '{0, 13, 15, 8};
        int cnt_list [4]   = '{15, 5, 3, 0};
        start_test("random_tiles");
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < ARRAY_N; i++) begin
                write_row(1'b1, ADDR_W'(wbase_list[r] + i), rand_row());
            end
            for (int a = 0; a < BUF_DEPTH; a++) begin
                write_row(1'b0, ADDR_W'(a), rand_row());
            end
            load_weights(ADDR_W'(wbase_list[r]));
            matmul(ADDR_W'(src_list[r]), ADDR_W'(dst_list[r]), CNT_W'(cnt_list[r]), 1'b0);
            for (int k = 0; k <= cnt_list[r]; k++) begin
                read_check(ADDR_W'(dst_list[r] + k), 0);
            end
        end
        end_test();
    endtask

    task automatic test_accumulate();
        start_test("accumulate");
        for (int i = 0; i < ARRAY_N; i++) begin
            write_row(1'b1, ADDR_W'(8 + i), rand_row());
            write_row(1'b0, ADDR_W'(2 + i), rand_row());
        end
        load_weights(4'd8);
        matmul(4'd2, 4'd10, 4'd3, 1'b0);
        matmul(4'd2, 4'd10, 4'd3, 1'b1);
        for (int k = 0; k < ARRAY_N; k++) begin
            read_check(ADDR_W'(10 + k), 0);
        end
        matmul(4'd2, 4'd10, 4'd3, 1'b0);
        for (int k = 0; k < ARRAY_N; k++) begin
            read_check(ADDR_W'(10 + k), 0);
        end
        // All -128, so 17 passes run past 2^20
        for (int i = 0; i < ARRAY_N; i++) begin
            write_row(1'b1, ADDR_W'(12 + i), {ARRAY_N{8'h80}});
        end
        write_row(1'b0, 4'd15, {ARRAY_N{8'h80}});
        load_weights(4'd12);
        matmul(4'd15, 4'd5, 4'd0, 1'b0);
        for (int n = 0; n < 16; n++) begin
            matmul(4'd15, 4'd5, 4'd0, 1'b1);
        end
        read_check(4'd5, 0);
        matmul(4'd15, 4'd5, 4'd0, 1'b0);
        read_check(4'd5, 0);
        end_test();
    endtask

    task automatic test_back_pressure();
        start_test("back_pressure");
        for (int n = 0; n < 6; n++) begin
            read_check(ADDR_W'($urandom % BUF_DEPTH), 1 + int'($urandom % 8));
        end
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        result_ready = 1'b0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset_state();
        test_identity();
        test_random_tiles();
        test_accumulate();
        test_back_pressure();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
